// File: hwpf_credit_issue.sv
// Cache must return exactly one credit per accepted request; output holds one cycle only
`default_nettype none
`timescale 1ns/1ps

`include "hwpf_defines.svh"

module hwpf_credit_issue (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 arb_valid_i,
    output logic                      arb_ready_o,
    input  wire hwpf_pkg::hwpf_req_t  arb_req_i,
    input  wire logic                 credit_return_i,
    output logic                      pf_req_valid_o,
    output hwpf_pkg::hwpf_addr_t      pf_req_addr_o,
    output hwpf_pkg::hwpf_tid_t       pf_req_tid_o
);

    localparam int CRED_W = $clog2(`HWPF_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`HWPF_CREDITS);

    logic [CRED_W-1:0]   credit_q;
    logic                xfer;
    logic                pf_valid_q;
    hwpf_pkg::hwpf_req_t pf_req_q;

    // Accept only with a credit in hand
    assign arb_ready_o = (credit_q != '0);
    assign xfer        = arb_valid_i && arb_ready_o;

    // Credit counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= CRED_MAX;
        end else if (xfer && !credit_return_i) begin
            credit_q <= credit_q - 1'b1;
        end else if (!xfer && credit_return_i && (credit_q != CRED_MAX)) begin
            // Saturates at the reset grant
            credit_q <= credit_q + 1'b1;
        end
    end

    // One-cycle request pulse
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pf_valid_q <= 1'b0;
        end else begin
            pf_valid_q <= xfer;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer) begin
            pf_req_q <= arb_req_i;
        end
    end

    assign pf_req_valid_o = pf_valid_q;
    assign pf_req_addr_o  = pf_req_q.addr;
    assign pf_req_tid_o   = pf_req_q.tid;

endmodule

`default_nettype wire

// File: hwpf_defines.svh
// Engine count must be a power of two and equal 2**HWPF_TID_W; credits set cache request depth
`ifndef HWPF_DEFINES_SVH
`define HWPF_DEFINES_SVH

// Number of stride engines sharing one cache port
`define HWPF_NUM_ENGINES 4

// Byte address width of trigger and prefetch addresses
`define HWPF_ADDR_W 32

// Request tid width, log2 of the engine count
`define HWPF_TID_W 2

// Credits granted by the cache after reset
`define HWPF_CREDITS 2

`endif

// File: hwpf_pkg.sv
// Types only; widths come from hwpf_defines.svh, stride is two's complement of address width
`default_nettype none

`include "hwpf_defines.svh"

package hwpf_pkg;

    // Byte address
    typedef logic [`HWPF_ADDR_W-1:0] hwpf_addr_t;

    // Signed distance between two trigger addresses
    typedef logic signed [`HWPF_ADDR_W-1:0] hwpf_stride_t;

    // Engine index, carried in the tid field
    typedef logic [`HWPF_TID_W-1:0] hwpf_tid_t;

    // Prefetch request toward the cache
    typedef struct packed {
        hwpf_addr_t addr;
        // Identifies the issuing engine for the response
        hwpf_tid_t  tid;
    } hwpf_req_t;

endpackage

`default_nettype wire

// File: hwpf_req_if.sv
// One engine-to-arbiter link; req_valid holds with stable req_addr until accepted
`default_nettype none
`timescale 1ns/1ps

interface hwpf_req_if;

    // Valid/ready request channel
    logic                 req_valid;
    logic                 req_ready;
    hwpf_pkg::hwpf_addr_t req_addr;

    // Completion pulse for the outstanding prefetch
    logic                 rsp_valid;

    // Engine side
    modport engine (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid
    );

    // Arbiter side
    modport arbiter (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid
    );

endinterface

`default_nettype wire

// File: hwpf_stride_arb.sv
// Combinational grant and response routing; engine count must be 2**HWPF_TID_W
`default_nettype none
`timescale 1ns/1ps

`include "hwpf_defines.svh"

module hwpf_stride_arb (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    hwpf_req_if.arbiter               links [0:`HWPF_NUM_ENGINES-1],
    output logic                      arb_valid_o,
    input  wire logic                 arb_ready_i,
    output hwpf_pkg::hwpf_req_t       arb_req_o,
    input  wire logic                 rsp_valid_i,
    input  wire hwpf_pkg::hwpf_tid_t  rsp_tid_i
);

    localparam int N = `HWPF_NUM_ENGINES;

    // Flattened link requests
    logic                 [N-1:0] req_valid;
    hwpf_pkg::hwpf_addr_t [N-1:0] req_addr;

    // One-hot grant and its index
    logic                 [N-1:0] gnt;
    hwpf_pkg::hwpf_tid_t          gnt_idx;

    // Highest priority engine this cycle
    hwpf_pkg::hwpf_tid_t          prio_q;

    // Per-link wiring
    for (genvar i = 0; i < N; i++) begin : gen_link
        assign req_valid[i] = links[i].req_valid;
        assign req_addr[i]  = links[i].req_addr;

        // Granted engine sees ready only while the issue stage accepts
        assign links[i].req_ready = gnt[i] & arb_ready_i;

        // Response goes to the engine named by its tid
        assign links[i].rsp_valid = rsp_valid_i &&
                                    (rsp_tid_i == hwpf_pkg::hwpf_tid_t'(i));
    end

    // Round-robin pick
    always_comb begin : rr_pick
        int idx;
        gnt_idx = prio_q;
        // Walk down so the engine closest to prio_q wins last
        for (int off = N - 1; off >= 0; off--) begin
            idx = (int'(prio_q) + off) % N;
            if (req_valid[idx]) begin
                gnt_idx = hwpf_pkg::hwpf_tid_t'(idx);
            end
        end
        gnt          = '0;
        gnt[gnt_idx] = |req_valid;
    end

    // Request mux with engine index as tid
    assign arb_valid_o    = |req_valid;
    assign arb_req_o.addr = req_addr[gnt_idx];
    assign arb_req_o.tid  = gnt_idx;

    // Priority moves past the winner on each transfer
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q <= '0;
        end else if (arb_valid_o && arb_ready_i) begin
            prio_q <= hwpf_pkg::hwpf_tid_t'((int'(gnt_idx) + 1) % N);
        end
    end

endmodule

`default_nettype wire

// File: hwpf_stride_engine.sv
// One trigger per cycle, one prefetch in flight, no page check; busy engines drop proposals
`default_nettype none
`timescale 1ns/1ps

module hwpf_stride_engine (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 trig_valid_i,
    input  wire hwpf_pkg::hwpf_addr_t trig_addr_i,
    hwpf_req_if.engine                link
);

    // Training state
    hwpf_pkg::hwpf_addr_t   last_addr_q;
    hwpf_pkg::hwpf_stride_t last_stride_q;
    logic                   seen_q;

    // Pending request slot and outstanding tracking
    logic                   pend_valid_q;
    hwpf_pkg::hwpf_addr_t   pend_addr_q;
    logic                   busy_q;

    // Per-trigger decode
    hwpf_pkg::hwpf_stride_t cur_stride;
    logic                   confirm;
    logic                   load;
    logic                   xfer;

    // Distance from the previous trigger
    assign cur_stride = hwpf_pkg::hwpf_stride_t'(trig_addr_i - last_addr_q);

    // Same nonzero stride twice in a row
    assign confirm = trig_valid_i && seen_q &&
                     (cur_stride == last_stride_q) && (cur_stride != '0);

    // Only with an empty slot and nothing in flight
    assign load = confirm && !pend_valid_q && !busy_q;

    // Slot handed to the arbiter
    assign xfer = pend_valid_q && link.req_ready;

    // Stride learning independent of slot state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            seen_q        <= 1'b0;
            last_addr_q   <= '0;
            last_stride_q <= '0;
        end else if (trig_valid_i) begin
            seen_q      <= 1'b1;
            last_addr_q <= trig_addr_i;
            // First trigger only records its address
            if (seen_q) begin
                last_stride_q <= cur_stride;
            end
        end
    end

    // Slot valid and busy flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_valid_q <= 1'b0;
            busy_q       <= 1'b0;
        end else begin
            if (load) begin
                pend_valid_q <= 1'b1;
            end else if (xfer) begin
                pend_valid_q <= 1'b0;
            end
            // Busy from transfer until the response pulse
            if (xfer) begin
                busy_q <= 1'b1;
            end else if (link.rsp_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Next address in the stream
    always_ff @(posedge clk_i) begin
        if (load) begin
            pend_addr_q <= trig_addr_i + hwpf_pkg::hwpf_addr_t'(cur_stride);
        end
    end

    // Slot drives the link directly
    assign link.req_valid = pend_valid_q;
    assign link.req_addr  = pend_addr_q;

endmodule

`default_nettype wire

// File: hwpf_top.f
+incdir+.
hwpf_pkg.sv
hwpf_req_if.sv
hwpf_stride_engine.sv
hwpf_stride_arb.sv
hwpf_credit_issue.sv
hwpf_top.sv
tb_hwpf_top.sv

// File: hwpf_top.sv
// Trigger lane i feeds engine i and tid i; latency is 2 cycles only with credit and no contention
`default_nettype none
`timescale 1ns/1ps

`include "hwpf_defines.svh"

module hwpf_top (
    input  wire logic                                         clk_i,
    input  wire logic                                         rst_n_i,
    input  wire logic [`HWPF_NUM_ENGINES-1:0]                 trig_valid_i,
    input  wire hwpf_pkg::hwpf_addr_t [`HWPF_NUM_ENGINES-1:0] trig_addr_i,
    output logic                                              pf_req_valid_o,
    output hwpf_pkg::hwpf_addr_t                              pf_req_addr_o,
    output hwpf_pkg::hwpf_tid_t                               pf_req_tid_o,
    input  wire logic                                         credit_return_i,
    input  wire logic                                         rsp_valid_i,
    input  wire hwpf_pkg::hwpf_tid_t                          rsp_tid_i
);

    // Engine to arbiter links
    hwpf_req_if link_if [0:`HWPF_NUM_ENGINES-1] ();

    // Arbiter to issue stage
    logic                arb_valid;
    logic                arb_ready;
    hwpf_pkg::hwpf_req_t arb_req;

    // One stride engine per trigger lane
    for (genvar i = 0; i < `HWPF_NUM_ENGINES; i++) begin : gen_engine
        hwpf_stride_engine u_engine (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .trig_valid_i (trig_valid_i[i]),
            .trig_addr_i  (trig_addr_i[i]),
            .link         (link_if[i])
        );
    end

    // Merge proposals, route responses back
    hwpf_stride_arb u_arb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .links       (link_if),
        .arb_valid_o (arb_valid),
        .arb_ready_i (arb_ready),
        .arb_req_o   (arb_req),
        .rsp_valid_i (rsp_valid_i),
        .rsp_tid_i   (rsp_tid_i)
    );

    // Credit-gated cache port
    hwpf_credit_issue u_issue (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .arb_valid_i     (arb_valid),
        .arb_ready_o     (arb_ready),
        .arb_req_i       (arb_req),
        .credit_return_i (credit_return_i),
        .pf_req_valid_o  (pf_req_valid_o),
        .pf_req_addr_o   (pf_req_addr_o),
        .pf_req_tid_o    (pf_req_tid_o)
    );

endmodule

`default_nettype wire

// File: tb_hwpf_top.sv
// Cache model returns one credit per request unless a row turns it off; rows run in table order
`default_nettype none
`timescale 1ns/1ps

`include "hwpf_defines.svh"

module tb_hwpf_top;

    localparam int N = `HWPF_NUM_ENGINES;

    // One scenario per row
    typedef struct {
        string               name;
        bit                  do_rst;
        bit                  rsp;
        hwpf_pkg::hwpf_tid_t rsp_tid;
        logic [N-1:0]        mask;
        bit                  irregular;
        logic [N-1:0]        exp_mask;
        bit                  auto_cred;
        int                  hold;
        bit                  lat;
    } row_t;

    logic                           clk_i;
    logic                           rst_n_i;
    logic [N-1:0]                   trig_valid_i;
    hwpf_pkg::hwpf_addr_t [N-1:0]   trig_addr_i;
    logic                           pf_req_valid_o;
    hwpf_pkg::hwpf_addr_t           pf_req_addr_o;
    hwpf_pkg::hwpf_tid_t            pf_req_tid_o;
    logic                           credit_return_i;
    logic                           rsp_valid_i;
    hwpf_pkg::hwpf_tid_t            rsp_tid_i;

    row_t                  rows [0:8];
    hwpf_pkg::hwpf_req_t   got [$];
    int                    got_cyc [$];
    hwpf_pkg::hwpf_req_t   mon_req;
    int                    cyc;
    int                    req_total;
    int                    cred_total;
    bit                    auto_cred;
    int                    passes;
    int                    fails;
    integer                seed;

    hwpf_top dut_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .trig_valid_i    (trig_valid_i),
        .trig_addr_i     (trig_addr_i),
        .pf_req_valid_o  (pf_req_valid_o),
        .pf_req_addr_o   (pf_req_addr_o),
        .pf_req_tid_o    (pf_req_tid_o),
        .credit_return_i (credit_return_i),
        .rsp_valid_i     (rsp_valid_i),
        .rsp_tid_i       (rsp_tid_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Cycle stamp for latency
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    // Output requests sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_n_i && pf_req_valid_o) begin
            mon_req.addr = pf_req_addr_o;
            mon_req.tid  = pf_req_tid_o;
            got.push_back(mon_req);
            got_cyc.push_back(cyc);
            req_total++;
        end
    end

    // Advance one cycle and clear pulses while the cache returns owed credits
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        trig_valid_i    = '0;
        rsp_valid_i     = 1'b0;
        credit_return_i = 1'b0;
        if (auto_cred && cred_total < req_total) begin
            credit_return_i = 1'b1;
            cred_total++;
        end
    endtask

    task automatic apply_reset();
        next_cycle();
        rst_n_i = 1'b0;
        next_cycle();
        next_cycle();
        rst_n_i = 1'b1;
        // Fresh credit pool in the DUT
        cred_total = req_total;
    endtask

    task automatic quiet_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic wait_requests(input string name, input int n);
        int t;
        t = 0;
        while (got.size() < n && t < 40) begin
            next_cycle();
            t++;
        end
        if (got.size() < n) begin
            $display("Test %s: timeout waiting for prefetch request", name);
            fails++;
        end
    endtask

    task automatic check_req(input string name, input hwpf_pkg::hwpf_req_t exp,
                             input hwpf_pkg::hwpf_req_t act);
        if (exp !== act) begin
            $display("Fail %s expected addr=%h tid=%0d actual addr=%h tid=%0d",
                     name, exp.addr, exp.tid, act.addr, act.tid);
            fails++;
        end else begin
            $display("Pass %s addr=%h tid=%0d", name, act.addr, act.tid);
            passes++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s expected %0d actual %0d", name, exp, act);
            fails++;
        end else begin
            $display("Pass %s %0d", name, act);
            passes++;
        end
    endtask

    task automatic run_row(input row_t r);
        hwpf_pkg::hwpf_addr_t base [N];
        hwpf_pkg::hwpf_addr_t stride [N];
        hwpf_pkg::hwpf_addr_t exp_addr [N];
        hwpf_pkg::hwpf_req_t  exp;
        int                   s;
        int                   n_exp;
        int                   first;
        int                   idx;
        int                   trig_cyc;
        int                   fails_before;
        fails_before = fails;
        auto_cred = r.auto_cred;
        if (r.do_rst) begin
            apply_reset();
        end
        got.delete();
        got_cyc.delete();
        // Line-aligned base and nonzero stride of either sign
        for (int e = 0; e < N; e++) begin
            base[e] = $random(seed) & 32'hffff_ffc0;
            s = ($random(seed) % 16) * 64;
            if (s == 0) begin
                s = 64;
            end
            stride[e]   = hwpf_pkg::hwpf_addr_t'(s);
            exp_addr[e] = base[e] + 32'd3 * stride[e];
        end
        if (r.rsp) begin
            next_cycle();
            rsp_valid_i = 1'b1;
            rsp_tid_i   = r.rsp_tid;
        end
        // A, A+S, then A+2S or A+3S when irregular
        for (int k = 0; k < 3; k++) begin
            next_cycle();
            trig_valid_i = r.mask;
            for (int e = 0; e < N; e++) begin
                trig_addr_i[e] = base[e] + stride[e] * 32'(k);
                if (k == 2 && r.irregular) begin
                    trig_addr_i[e] = base[e] + 32'd3 * stride[e];
                end
            end
        end
        trig_cyc = cyc;
        n_exp = $countones(r.exp_mask);
        first = (r.hold >= 0) ? r.hold : n_exp;
        wait_requests(r.name, first);
        quiet_cycles(10);
        check_count({r.name, "_count"}, first, got.size());
        if (r.hold >= 0) begin
            // One credit releases the withheld request
            next_cycle();
            credit_return_i = 1'b1;
            wait_requests(r.name, n_exp);
            quiet_cycles(10);
            check_count({r.name, "_released"}, n_exp, got.size());
        end
        // Round-robin from engine 0 gives ascending tid order
        idx = 0;
        for (int e = 0; e < N; e++) begin
            if (r.exp_mask[e]) begin
                exp.addr = exp_addr[e];
                exp.tid  = hwpf_pkg::hwpf_tid_t'(e);
                if (idx < got.size()) begin
                    check_req($sformatf("%s_req%0d", r.name, idx), exp, got[idx]);
                end
                idx++;
            end
        end
        if (r.lat && got.size() > 0) begin
            check_count({r.name, "_latency"}, 2, got_cyc[0] - trig_cyc);
        end
        $display("Test %s finished with %0d errors", r.name, fails - fails_before);
    endtask

    initial begin
        rst_n_i         = 1'b0;
        trig_valid_i    = '0;
        trig_addr_i     = '0;
        credit_return_i = 1'b0;
        rsp_valid_i     = 1'b0;
        rsp_tid_i       = '0;
        cyc             = 0;
        req_total       = 0;
        cred_total      = 0;
        auto_cred       = 1'b1;
        passes          = 0;
        fails           = 0;
        seed            = 32'h1d391650;
        // name, rst, rsp, tid, mask, irregular, expected, auto credit, hold, latency
        rows[0] = '{"idle_after_reset", 1, 0, 0, 4'b0000, 0, 4'b0000, 1, -1, 0};
        rows[1] = '{"stride_engine0", 1, 0, 0, 4'b0001, 0, 4'b0001, 1, -1, 1};
        rows[2] = '{"irregular_engine0", 1, 0, 0, 4'b0001, 1, 4'b0000, 1, -1, 0};
        rows[3] = '{"engine1_first", 1, 0, 0, 4'b0010, 0, 4'b0010, 1, -1, 1};
        rows[4] = '{"engine1_busy_drop", 0, 0, 0, 4'b0010, 0, 4'b0000, 1, -1, 0};
        rows[5] = '{"engine1_after_rsp", 0, 1, 1, 4'b0010, 0, 4'b0010, 1, -1, 1};
        rows[6] = '{"credit_backpressure", 1, 0, 0, 4'b0111, 0, 4'b0111, 0, 2, 0};
        rows[7] = '{"all_engines_tid_order", 1, 0, 0, 4'b1111, 0, 4'b1111, 1, -1, 0};
        rows[8] = '{"rsp_frees_engine2", 0, 1, 2, 4'b1100, 0, 4'b0100, 1, -1, 0};
        for (int i = 0; i < 9; i++) begin
            run_row(rows[i]);
        end
        $display("Checks passed %0d, failed %0d", passes, fails);
        if (fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
